// File: hdl/ebus_pkg.sv
`default_nettype none

package ebus_pkg;

    // Bank number width for the 512 KB external RAM (16 KB pages)
    localparam int bank_w = 5;

    typedef logic [bank_w-1:0] bank_t;
    typedef logic [7:0]        byte_t;

    // Same 16-bit bus address, seen as a memory address or as an IO port
    typedef union packed {
        struct packed {
            logic [1:0]  page;
            logic [13:0] offset;
        } mem;
        struct packed {
            logic [7:0] upper;
            logic [7:0] port;
        } io;
    } ebus_addr_u;

    // Registers at the top of page 3
    localparam logic [15:0] addr_ctrl  = 16'hFFFC;
    localparam logic [15:0] addr_bank0 = 16'hFFFD;
    localparam logic [15:0] addr_bank1 = 16'hFFFE;
    localparam logic [15:0] addr_bank2 = 16'hFFFF;

    // Page 0 stays on bank 0 below this address
    localparam logic [15:0] boot_low_limit = 16'h0400;

    // IO selector codes from port bits 7, 6 and 0
    localparam logic [2:0] port_joy1 = 3'b110;
    localparam logic [2:0] port_joy2 = 3'b111;

    localparam bank_t bank0_reset = bank_t'(0);
    localparam bank_t bank1_reset = bank_t'(1);
    localparam bank_t bank2_reset = bank_t'(2);

endpackage

`default_nettype wire

// File: hdl/ebus_strobe_sync.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_strobe_sync (
    input  logic              clk,
    input  logic              reset,
    input  logic              rd_n,
    input  logic              wr_n,
    input  ebus_pkg::byte_t   bus_d_in,
    output logic              bus_read,
    output logic              bus_write,
    output ebus_pkg::byte_t   wr_data
);

    // Strobe history, bit 0 is the newest sample
    logic [2:0] rd_sr;
    logic [2:0] wr_sr;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_sr <= 3'b111;
            wr_sr <= 3'b111;
        end else begin
            rd_sr <= {rd_sr[1:0], rd_n};
            wr_sr <= {wr_sr[1:0], wr_n};
        end
    end

    // Falling edge seen between the two oldest stages
    assign bus_read  = rd_sr[2] && !rd_sr[1];
    assign bus_write = wr_sr[2] && !wr_sr[1];

    // Data is stable for the whole strobe, so just follow it while low
    always_ff @(posedge clk) begin
        if (!wr_n) begin
            wr_data <= bus_d_in;
        end
    end

endmodule

`default_nettype wire

// File: hdl/ebus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_decode (
    input  ebus_pkg::ebus_addr_u bus_a,
    input  logic                 mreq_n,
    input  logic                 iorq_n,
    input  logic                 wr_n,
    input  logic                 startup_mode,
    input  ebus_pkg::bank_t      bank0,
    input  ebus_pkg::bank_t      bank1,
    input  ebus_pkg::bank_t      bank2,
    output logic                 sel_int_ram,
    output logic                 sel_bank0,
    output logic                 sel_bank1,
    output logic                 sel_bank2,
    output logic                 sel_ctrl,
    output logic                 sel_joy1,
    output logic                 sel_joy2,
    output logic                 sel_internal,
    output ebus_pkg::bank_t      bank_addr,
    output logic                 ram_ce_n,
    output logic                 ram_we_n
);

    logic       mem_cycle;
    logic       io_cycle;
    logic       ext_mem;
    logic [2:0] io_sel;

    assign mem_cycle = !mreq_n;
    assign io_cycle  = !iorq_n;

    ////////////////////////////////////////////////////////////////////////////
    // Memory space
    ////////////////////////////////////////////////////////////////////////////

    // Page 3 is internal, registers overlay its last four bytes
    assign sel_int_ram = mem_cycle && (bus_a.mem.page == 2'b11);
    assign sel_ctrl    = mem_cycle && (bus_a == ebus_pkg::addr_ctrl);
    assign sel_bank0   = mem_cycle && (bus_a == ebus_pkg::addr_bank0);
    assign sel_bank1   = mem_cycle && (bus_a == ebus_pkg::addr_bank1);
    assign sel_bank2   = mem_cycle && (bus_a == ebus_pkg::addr_bank2);

    always_comb begin
        case (bus_a.mem.page)
            2'b00: begin
                if (bus_a < ebus_pkg::boot_low_limit) begin
                    bank_addr = '0;
                end else begin
                    bank_addr = bank0;
                end
            end
            2'b01:   bank_addr = bank1;
            2'b10:   bank_addr = bank2;
            default: bank_addr = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // IO space
    ////////////////////////////////////////////////////////////////////////////

    // Partial decoding on port bits 7, 6 and 0
    assign io_sel   = {bus_a.io.port[7], bus_a.io.port[6], bus_a.io.port[0]};
    assign sel_joy1 = io_cycle && (io_sel == ebus_pkg::port_joy1);
    assign sel_joy2 = io_cycle && (io_sel == ebus_pkg::port_joy2);

    assign sel_internal = io_cycle || sel_int_ram;

    // External RAM turns read-only once startup mode ends
    assign ext_mem  = mem_cycle && !sel_internal;
    assign ram_ce_n = !(ext_mem && (wr_n || startup_mode));
    assign ram_we_n = !(ext_mem && !wr_n && startup_mode);

endmodule

`default_nettype wire

// File: hdl/ebus_bank_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_bank_regs (
    input  logic             clk,
    input  logic             reset,
    input  logic             bus_write,
    input  ebus_pkg::byte_t  wr_data,
    input  logic             sel_bank0,
    input  logic             sel_bank1,
    input  logic             sel_bank2,
    input  logic             sel_ctrl,
    output ebus_pkg::bank_t  bank0,
    output ebus_pkg::bank_t  bank1,
    output ebus_pkg::bank_t  bank2,
    output logic             startup_mode
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank0        <= ebus_pkg::bank0_reset;
            bank1        <= ebus_pkg::bank1_reset;
            bank2        <= ebus_pkg::bank2_reset;
            startup_mode <= 1'b1;
        end else if (bus_write) begin
            if (sel_bank0) begin
                bank0 <= wr_data[ebus_pkg::bank_w-1:0];
            end
            if (sel_bank1) begin
                bank1 <= wr_data[ebus_pkg::bank_w-1:0];
            end
            if (sel_bank2) begin
                bank2 <= wr_data[ebus_pkg::bank_w-1:0];
            end
            // Leaving startup mode is one-way until the next reset
            if (sel_ctrl) begin
                startup_mode <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/ebus_int_ram.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_int_ram #(
    parameter int ram_addr_w = 13
) (
    input  logic                  clk,
    input  logic [ram_addr_w-1:0] addr,
    input  ebus_pkg::byte_t       wr_data,
    input  logic                  wren,
    output ebus_pkg::byte_t       rd_data
);

    ebus_pkg::byte_t mem [0:(1 << ram_addr_w) - 1];

    // Read-before-write, the read port sees the old byte
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[addr] <= wr_data;
        end
        rd_data <= mem[addr];
    end

endmodule

`default_nettype wire

// File: hdl/ebus_pad_port.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_pad_port (
    input  logic             clk,
    input  logic             reset,
    input  logic [7:0]       pad1,
    input  logic [7:0]       pad2,
    output ebus_pkg::byte_t  joy1,
    output ebus_pkg::byte_t  joy2
);

    logic [7:0] pad1_meta;
    logic [7:0] pad1_sync;
    logic [7:0] pad2_meta;
    logic [7:0] pad2_sync;

    // Pads are active low, so idle is all ones
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pad1_meta <= 8'hFF;
            pad1_sync <= 8'hFF;
            pad2_meta <= 8'hFF;
            pad2_sync <= 8'hFF;
        end else begin
            pad1_meta <= pad1;
            pad1_sync <= pad1_meta;
            pad2_meta <= pad2;
            pad2_sync <= pad2_meta;
        end
    end

    // Buttons 2 and 1, then right, left, down, up
    function automatic ebus_pkg::byte_t joy_map(input logic [7:0] p);
        return {2'b11, p[6], p[5], p[1], p[3], p[0], p[2]};
    endfunction

    assign joy1 = joy_map(pad1_sync);
    assign joy2 = joy_map(pad2_sync);

endmodule

`default_nettype wire

// File: hdl/ebus_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_read_mux (
    input  logic             rd_n,
    input  logic             sel_internal,
    input  logic             sel_int_ram,
    input  logic             sel_joy1,
    input  logic             sel_joy2,
    input  ebus_pkg::byte_t  ram_rd_data,
    input  ebus_pkg::byte_t  joy1,
    input  ebus_pkg::byte_t  joy2,
    output ebus_pkg::byte_t  bus_d_out,
    output logic             bus_d_oe
);

    // Unmapped internal reads float high like an open bus
    always_comb begin
        bus_d_out = 8'hFF;
        if (sel_int_ram) begin
            bus_d_out = ram_rd_data;
        end
        if (sel_joy1) begin
            bus_d_out = joy1;
        end
        if (sel_joy2) begin
            bus_d_out = joy2;
        end
    end

    // Only drive the host bus for our own address space
    assign bus_d_oe = !rd_n && sel_internal;

endmodule

`default_nettype wire

// File: hdl/ebus_top.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_top #(
    parameter int ram_addr_w = 13
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [15:0]      bus_a,
    input  ebus_pkg::byte_t  bus_d_in,
    input  logic             rd_n,
    input  logic             wr_n,
    input  logic             mreq_n,
    input  logic             iorq_n,
    input  logic [7:0]       pad1,
    input  logic [7:0]       pad2,
    output ebus_pkg::byte_t  bus_d_out,
    output logic             bus_d_oe,
    output ebus_pkg::bank_t  bank_addr,
    output logic             ram_ce_n,
    output logic             ram_we_n
);

    // Write strobe pulse and captured data
    logic             bus_write;
    ebus_pkg::byte_t  wr_data;

    logic sel_int_ram, sel_bank0, sel_bank1, sel_bank2, sel_ctrl;
    logic sel_joy1, sel_joy2, sel_internal;

    ebus_pkg::bank_t  bank0, bank1, bank2;
    logic             startup_mode;
    logic             ram_wren;
    ebus_pkg::byte_t  ram_rd_data;
    ebus_pkg::byte_t  joy1, joy2;

    assign ram_wren = sel_int_ram && bus_write;

    ////////////////////////////////////////////////////////////////////////////
    // Bus front end and decode
    ////////////////////////////////////////////////////////////////////////////
    ebus_strobe_sync u_strobe_sync (
        .clk(clk), .reset(reset), .rd_n(rd_n), .wr_n(wr_n), .bus_d_in(bus_d_in),
        .bus_read(), .bus_write(bus_write), .wr_data(wr_data)
    );

    ebus_decode u_decode (
        .bus_a(bus_a), .mreq_n(mreq_n), .iorq_n(iorq_n), .wr_n(wr_n),
        .startup_mode(startup_mode), .bank0(bank0), .bank1(bank1), .bank2(bank2),
        .sel_int_ram(sel_int_ram), .sel_bank0(sel_bank0), .sel_bank1(sel_bank1),
        .sel_bank2(sel_bank2), .sel_ctrl(sel_ctrl), .sel_joy1(sel_joy1),
        .sel_joy2(sel_joy2), .sel_internal(sel_internal), .bank_addr(bank_addr),
        .ram_ce_n(ram_ce_n), .ram_we_n(ram_we_n)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Registers, memory and ports
    ////////////////////////////////////////////////////////////////////////////
    ebus_bank_regs u_bank_regs (
        .clk(clk), .reset(reset), .bus_write(bus_write), .wr_data(wr_data),
        .sel_bank0(sel_bank0), .sel_bank1(sel_bank1), .sel_bank2(sel_bank2),
        .sel_ctrl(sel_ctrl), .bank0(bank0), .bank1(bank1), .bank2(bank2),
        .startup_mode(startup_mode)
    );

    // Smaller RAMs alias inside page 3
    ebus_int_ram #(.ram_addr_w(ram_addr_w)) u_int_ram (
        .clk(clk), .addr(bus_a[ram_addr_w-1:0]), .wr_data(wr_data),
        .wren(ram_wren), .rd_data(ram_rd_data)
    );

    ebus_pad_port u_pad_port (
        .clk(clk), .reset(reset), .pad1(pad1), .pad2(pad2), .joy1(joy1), .joy2(joy2)
    );

    ebus_read_mux u_read_mux (
        .rd_n(rd_n), .sel_internal(sel_internal), .sel_int_ram(sel_int_ram),
        .sel_joy1(sel_joy1), .sel_joy2(sel_joy2), .ram_rd_data(ram_rd_data),
        .joy1(joy1), .joy2(joy2), .bus_d_out(bus_d_out), .bus_d_oe(bus_d_oe)
    );

endmodule

`default_nettype wire

// File: sim/ebus_tb_sva.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_tb_sva (
    input  logic             clk,
    input  logic             reset,
    input  logic [15:0]      bus_a,
    input  ebus_pkg::bank_t  bank_addr,
    input  logic             ram_ce_n,
    input  logic             ram_we_n,
    input  logic             bus_d_oe
);

    // External RAM and host-side drive never overlap
    ce_oe_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(!ram_ce_n && bus_d_oe))
        else $error("ram_ce_n and bus_d_oe active in the same cycle");

    // A write strobe only ever goes out with a chip select
    we_needs_ce: assert property (@(posedge clk) disable iff (reset)
        !ram_we_n |-> !ram_ce_n)
        else $error("ram_we_n low while ram_ce_n is high");

    // Page 3 lives inside the bridge
    page3_bank0: assert property (@(posedge clk) disable iff (reset)
        (bus_a[15:14] == 2'b11) |-> (bank_addr == '0))
        else $error("bank_addr is not 0 for a page 3 address");

endmodule

bind ebus_top ebus_tb_sva u_sva (
    .clk(clk), .reset(reset), .bus_a(bus_a), .bank_addr(bank_addr),
    .ram_ce_n(ram_ce_n), .ram_we_n(ram_we_n), .bus_d_oe(bus_d_oe)
);

`default_nettype wire

// File: sim/ebus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_tb;

    localparam int ram_addr_w = 13;

    logic             clk;
    logic             reset;
    logic [15:0]      bus_a;
    ebus_pkg::byte_t  bus_d_in;
    logic             rd_n;
    logic             wr_n;
    logic             mreq_n;
    logic             iorq_n;
    logic [7:0]       pad1;
    logic [7:0]       pad2;
    ebus_pkg::byte_t  bus_d_out;
    logic             bus_d_oe;
    ebus_pkg::bank_t  bank_addr;
    logic             ram_ce_n;
    logic             ram_we_n;

    // Reference model state
    ebus_pkg::bank_t  m_bank [3];
    bit               m_startup;
    ebus_pkg::byte_t  m_ram [0:(1 << ram_addr_w) - 1];
    logic [15:0]      written [$];

    string cur_test;
    int    checks;
    int    errors;
    int    test_checks;
    int    test_errors;
    int    tests;

    ebus_top #(.ram_addr_w(ram_addr_w)) u_dut (
        .clk(clk), .reset(reset), .bus_a(bus_a), .bus_d_in(bus_d_in), .rd_n(rd_n),
        .wr_n(wr_n), .mreq_n(mreq_n), .iorq_n(iorq_n), .pad1(pad1), .pad2(pad2),
        .bus_d_out(bus_d_out), .bus_d_oe(bus_d_oe), .bank_addr(bank_addr),
        .ram_ce_n(ram_ce_n), .ram_we_n(ram_we_n)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Model rules
    ////////////////////////////////////////////////////////////////////////////

    function automatic ebus_pkg::bank_t expected_bank(input ebus_pkg::ebus_addr_u a);
        if (a.mem.page == 2'b00) begin
            return (a < ebus_pkg::boot_low_limit) ? ebus_pkg::bank_t'(0) : m_bank[0];
        end
        if (a.mem.page == 2'b11) begin
            return ebus_pkg::bank_t'(0);
        end
        return m_bank[a.mem.page];
    endfunction

    function automatic ebus_pkg::byte_t expected_joy(input logic [7:0] p);
        ebus_pkg::byte_t j;
        j[7] = 1'b1;
        j[6] = 1'b1;
        j[5] = p[6];
        j[4] = p[5];
        j[3] = p[1];
        j[2] = p[3];
        j[1] = p[0];
        j[0] = p[2];
        return j;
    endfunction

    function automatic ebus_pkg::ebus_addr_u random_addr(input logic [1:0] page);
        ebus_pkg::ebus_addr_u a;
        a.mem.page   = page;
        // Bias some offsets under the boot limit
        a.mem.offset = ($urandom % 2) ? 14'($urandom) : 14'($urandom % 16'h0600);
        return a;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and report
    ////////////////////////////////////////////////////////////////////////////

    task automatic note_check(input bit bad, input string what, input string exp_s,
                              input string act_s);
        checks++;
        test_checks++;
        if (bad) begin
            errors++;
            test_errors++;
            $display("Fail %s %s: expected %s, actual %s", cur_test, what, exp_s, act_s);
        end
    endtask

    task automatic check_byte(input string what, input ebus_pkg::byte_t exp,
                              input ebus_pkg::byte_t act);
        note_check(exp !== act, what, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_bank(input string what, input ebus_pkg::bank_t exp,
                              input ebus_pkg::bank_t act);
        note_check(exp !== act, what, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    task automatic check_sel(input string what, input bit exp, input logic act);
        note_check(exp !== act, what, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
    endtask

    task automatic abort_run(input string why);
        $display("Error: %s", why);
        $display("** FAIL **");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus cycles
    ////////////////////////////////////////////////////////////////////////////

    // Strobe held 6 cycles, then 3 idle
    task automatic hold_and_release(output ebus_pkg::byte_t rdata, output bit oe,
                                    output bit ce_n, output bit we_n, output bit seen_oe);
        int n;
        seen_oe = 1'b0;
        for (n = 0; n < 6; n++) begin
            @(negedge clk);
            if (bus_d_oe) begin
                seen_oe = 1'b1;
            end
        end
        rdata = bus_d_out;
        oe    = bus_d_oe;
        ce_n  = ram_ce_n;
        we_n  = ram_we_n;
        @(posedge clk);
        rd_n   <= 1'b1;
        wr_n   <= 1'b1;
        mreq_n <= 1'b1;
        iorq_n <= 1'b1;
        for (n = 0; n < 3; n++) begin
            @(posedge clk);
        end
    endtask

    task automatic bus_write_cycle(input ebus_pkg::ebus_addr_u a, input ebus_pkg::byte_t d,
                                   input bit io, output bit ce_n, output bit we_n);
        ebus_pkg::byte_t rdata;
        bit              oe;
        bit              seen_oe;
        @(posedge clk);
        bus_a    <= a;
        bus_d_in <= d;
        mreq_n   <= io;
        iorq_n   <= !io;
        wr_n     <= 1'b0;
        hold_and_release(rdata, oe, ce_n, we_n, seen_oe);
        if (!io && a.mem.page == 2'b11) begin
            m_ram[a[ram_addr_w-1:0]] = d;
            if (a == ebus_pkg::addr_ctrl) m_startup = 1'b0;
            if (a == ebus_pkg::addr_bank0) m_bank[0] = d[ebus_pkg::bank_w-1:0];
            if (a == ebus_pkg::addr_bank1) m_bank[1] = d[ebus_pkg::bank_w-1:0];
            if (a == ebus_pkg::addr_bank2) m_bank[2] = d[ebus_pkg::bank_w-1:0];
        end
    endtask

    task automatic bus_read_cycle(input ebus_pkg::ebus_addr_u a, input bit io,
                                  output ebus_pkg::byte_t rdata, output bit oe,
                                  output bit ce_n, output bit we_n);
        bit seen_oe;
        @(posedge clk);
        bus_a  <= a;
        mreq_n <= io;
        iorq_n <= !io;
        rd_n   <= 1'b0;
        hold_and_release(rdata, oe, ce_n, we_n, seen_oe);
        if ((io || a.mem.page == 2'b11) && !seen_oe) begin
            abort_run("bus_d_oe never rose during an internal read");
        end
    endtask

    task automatic probe_bank(input ebus_pkg::ebus_addr_u a);
        @(posedge clk);
        bus_a  <= a;
        mreq_n <= 1'b0;
        @(negedge clk);
        check_bank($sformatf("bank_addr at %h", a), expected_bank(a), bank_addr);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        int w;
        for (w = 0; w < 20000; w++) begin
            @(posedge clk);
        end
        abort_run("timeout, the run exceeded its cycle limit");
    end

    initial begin : main
        ebus_pkg::ebus_addr_u a;
        ebus_pkg::byte_t      d;
        ebus_pkg::byte_t      rdata;
        bit                   oe;
        bit                   ce_n;
        bit                   we_n;
        int                   i;
        int                   k;
        int unsigned          seed_ret;

        seed_ret  = $urandom(32'h7dd40135);
        reset    <= 1'b1;
        bus_a    <= '0;
        bus_d_in <= '0;
        rd_n     <= 1'b1;
        wr_n     <= 1'b1;
        mreq_n   <= 1'b1;
        iorq_n   <= 1'b1;
        pad1     <= 8'hFF;
        pad2     <= 8'hFF;
        m_bank    = '{ebus_pkg::bank0_reset, ebus_pkg::bank1_reset, ebus_pkg::bank2_reset};
        m_startup = 1'b1;
        for (i = 0; i < 8; i++) begin
            @(posedge clk);
        end
        reset <= 1'b0;

        start_test("reset_banks");
        for (i = 0; i < 24; i++) begin
            probe_bank(random_addr(2'($urandom)));
        end
        end_test();

        start_test("bank_writes");
        for (i = 0; i < 12; i++) begin
            k = $urandom % 3;
            d = 8'($urandom);
            bus_write_cycle(ebus_pkg::addr_bank0 + 16'(k), d, 1'b0, ce_n, we_n);
            for (k = 0; k < 4; k++) begin
                probe_bank(random_addr(2'($urandom % 3)));
            end
        end
        end_test();

        // Startup writes first, then leave startup mode
        start_test("startup_ext");
        for (i = 0; i < 6; i++) begin
            bus_write_cycle(random_addr(2'($urandom % 3)), 8'($urandom), 1'b0, ce_n, we_n);
            check_sel("ram_ce_n on startup write", 1'b0, ce_n);
            check_sel("ram_we_n on startup write", 1'b0, we_n);
        end
        bus_write_cycle(ebus_pkg::addr_ctrl, 8'($urandom), 1'b0, ce_n, we_n);
        for (i = 0; i < 6; i++) begin
            bus_write_cycle(random_addr(2'($urandom % 3)), 8'($urandom), 1'b0, ce_n, we_n);
            check_sel("ram_ce_n on locked write", !m_startup, ce_n);
            check_sel("ram_we_n on locked write", 1'b1, we_n);
            bus_read_cycle(random_addr(2'($urandom % 3)), 1'b0, rdata, oe, ce_n, we_n);
            check_sel("ram_ce_n on read", 1'b0, ce_n);
            check_sel("ram_we_n on read", 1'b1, we_n);
            check_sel("bus_d_oe on external read", 1'b0, oe);
        end
        end_test();

        start_test("int_ram");
        for (i = 0; i < 36; i++) begin
            a = (i < 4) ? ebus_pkg::addr_ctrl + 16'(i) : random_addr(2'b11);
            d = 8'($urandom);
            bus_write_cycle(a, d, 1'b0, ce_n, we_n);
            written.push_back(a);
            a = written[$urandom % written.size()];
            bus_read_cycle(a, 1'b0, rdata, oe, ce_n, we_n);
            check_byte($sformatf("bus_d_out at %h", a), m_ram[a[ram_addr_w-1:0]], rdata);
            check_sel("bus_d_oe on page 3 read", 1'b1, oe);
        end
        end_test();

        start_test("pads");
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            pad1 <= 8'($urandom);
            pad2 <= 8'($urandom);
            for (k = 0; k < 3; k++) begin
                @(posedge clk);
            end
            a.io.upper = 8'($urandom);
            a.io.port  = (8'($urandom) & 8'h3E) | 8'hC0;
            bus_read_cycle(a, 1'b1, rdata, oe, ce_n, we_n);
            check_byte("joy1", expected_joy(pad1), rdata);
            a.io.port  = 8'($urandom) | 8'hC1;
            bus_read_cycle(a, 1'b1, rdata, oe, ce_n, we_n);
            check_byte("joy2", expected_joy(pad2), rdata);
            a.io.port  = 8'($urandom) & 8'hBF;
            bus_read_cycle(a, 1'b1, rdata, oe, ce_n, we_n);
            check_byte($sformatf("unmapped port %h", a.io.port), 8'hFF, rdata);
            check_sel("bus_d_oe on IO read", 1'b1, oe);
            check_sel("ram_ce_n on IO read", 1'b1, ce_n);
        end
        end_test();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/ebus_pkg.sv
hdl/ebus_strobe_sync.sv
hdl/ebus_decode.sv
hdl/ebus_bank_regs.sv
hdl/ebus_int_ram.sv
hdl/ebus_pad_port.sv
hdl/ebus_read_mux.sv
hdl/ebus_top.sv
sim/ebus_tb_sva.sv
sim/ebus_tb.sv

// File: Bender.yml
package:
  name: ebus_bridge

sources:
  - hdl/ebus_pkg.sv
  - hdl/ebus_strobe_sync.sv
  - hdl/ebus_decode.sv
  - hdl/ebus_bank_regs.sv
  - hdl/ebus_int_ram.sv
  - hdl/ebus_pad_port.sv
  - hdl/ebus_read_mux.sv
  - hdl/ebus_top.sv
  - target: test
    files:
      - sim/ebus_tb_sva.sv
      - sim/ebus_tb.sv
